/* test/stim_input.txt */
// Columns: command code, operand A, operand B, expected value, all 32-bit hex words
// Codes: 0 MOUSE 1 STICK 2 HALT 3 CTLWR 4 CTLRD 5 BLOCK 6 ACK 7 MOUNT 8 HOSTWR 9 HOSTRD
0 00001E00 00000100 000A5500 // X +30 limited to +10
0 00001E00 00000B00 00785500
0 00001E00 00000200 007F5500 // clamps at 127
0 0000E210 00000100 00755500 // X -30 limited to -10
0 0000E210 00001900 00805500 // clamps at -128
0 00050000 00000101 FB805500 // Y +5 inverted
0 00140003 00000100 0580550C // Y +20 limited, both buttons
0 00000003 00000102 33558003 // ports swapped
2 00000001 00000000 00005500 // halt hands back to the stick
2 00000000 00000000 00005500
0 00000300 00000100 00035500 // axes restart from zero
1 00004422 00000000 44225500 // stick moves
1 00000000 00000000 00005500
3 12345678 00000001 12345678 // LBA load
3 000000AA 00000000 12345678
3 000000BB 00000000 12345678
3 000000CC 00000100 12345678 // last byte, then io_wr
9 00000000 00000000 000000AA
9 00000001 00000000 000000BB
9 00000002 00000000 000000CC
8 00000000 00000011 00000011
8 00000001 00000022 00000022
8 00000002 00000033 00000033
4 00000000 00000000 00000011
4 00000000 00000000 00000022
4 00000000 00000000 00000033
7 00012345 00000122 0000C600 // mount slot 1, type 2, read-only
7 00012345 00000000 0000C600
4 00000000 00000001 00012345 // image size in LBA mode
5 00000000 00000022 0000C604 // block read on drive 4 goes to slot 2
6 00000004 00000000 0000C600
6 00000000 00000000 0000C700
5 00000000 00000000 0000C700
5 00000000 00000022 0000C604
6 00000004 00000000 0000C600
6 00000000 00000000 0000C700

/* flist.f */
hdl/io_bridge_pkg.sv
hdl/mouse_step_if.sv
hdl/mouse_packet_decoder.sv
hdl/axis_integrator.sv
hdl/joystick_select.sv
hdl/sector_buffer.sv
hdl/disk_bridge.sv
hdl/emu_io_top.sv
test/emu_io_chk.sv
test/emu_io_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
LINT     := --lint-only --timing --assert -Wall -Wno-fatal
TOP      := emu_io_tb
FLIST    := flist.f
OBJDIR   := obj_dir
PASS_MSG := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

/* test/emu_io_tb.sv */
// Testbench for the I/O bridge top level, replays the records of test/stim_input.txt
`timescale 1ns/1ps

module emu_io_tb;

	typedef enum logic [3:0] {
		MOUSE, STICK, HALT, CTLWR, CTLRD, BLOCK, ACK, MOUNT, HOSTWR, HOSTRD
	} tb_cmd_e;

	localparam int REC_WORDS    = 4;
	localparam int MAX_RECS     = 64;
	localparam int DONE_TIMEOUT = 16;

	logic clk_sys;
	logic areset;

	logic [24:0] mouse_i;
	logic        invert_y_i;
	logic        cpu_halt_i;
	logic [15:0] stick_a_i;
	logic [15:0] stick_b_i;
	logic [13:0] joy_a_i;
	logic [13:0] joy_b_i;
	logic        swap_i;
	logic [7:0]  joy1x_o;
	logic [7:0]  joy1y_o;
	logic [7:0]  joy2x_o;
	logic [7:0]  joy2y_o;
	logic [13:0] joy1_o;
	logic [13:0] joy2_o;

	logic [5:0]                 ctl_sel_i;
	logic [31:0]                ctl_data_i;
	logic                       ctl_data_wr_i;
	logic                       ctl_data_rd_i;
	logic                       ctl_io_wr_i;
	logic [7:0]                 status_o;
	logic [31:0]                ctl_word_o;
	logic [31:0]                sd_lba_o;
	logic [2:0]                 sd_rd_o;
	logic [2:0]                 sd_wr_o;
	logic [2:0]                 sd_ack_i;
	logic [2:0]                 img_mounted_i;
	logic                       img_readonly_i;
	logic [31:0]                img_size_i;
	logic [1:0]                 img_type_i;
	io_bridge_pkg::buf_addr_t   host_addr_i;
	logic [7:0]                 host_data_i;
	logic                       host_wr_i;
	logic [7:0]                 host_data_o;

	logic [31:0] stim_mem [MAX_RECS*REC_WORDS];
	logic        mouse_tog;

	// Expected mouse Y axis and emulation flag
	int          y_exp;
	logic        emu_exp;

	emu_io_top u_dut (.*);

	bind emu_io_top emu_io_chk u_chk (
		.clk_sys  (clk_sys),
		.areset   (areset),
		.ack_i    (sd_ack_i),
		.rd_req_i (sd_rd_o),
		.wr_req_i (sd_wr_o),
		.status_i (status_o),
		.axis_x_i (axis_val[0]),
		.axis_y_i (axis_val[1])
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else
			fail_run($sformatf("mismatch %s expected %08h actual %08h", name, expected, actual));
	endtask

	// Inputs change a short time after the edge
	task automatic next_edge();
		@(posedge clk_sys);
		#5;
	endtask

	task automatic pulse_io_wr();
		ctl_io_wr_i = 1'b1;
		next_edge();
		ctl_io_wr_i = 1'b0;
	endtask

	// Port 1 axes, port 2 X, then buttons 8 and 7 of both ports
	function automatic logic [31:0] joy_probe();
		return {joy1y_o, joy1x_o, joy2x_o, 4'h0, joy1_o[8], joy1_o[7], joy2_o[8], joy2_o[7]};
	endfunction

	function automatic logic [31:0] disk_probe();
		return {16'h0, status_o, 1'b0, sd_wr_o, 1'b0, sd_rd_o};
	endfunction

	// Signed 9-bit delta with its sign bit in byte 0, cut to the step limit
	function automatic int limited_step(input logic sign, input logic [7:0] mag);
		int d;
		d = sign ? int'(mag) - 256 : int'(mag);
		if (d > io_bridge_pkg::STEP_LIMIT) begin
			d = io_bridge_pkg::STEP_LIMIT;
		end else if (d < -io_bridge_pkg::STEP_LIMIT) begin
			d = -io_bridge_pkg::STEP_LIMIT;
		end
		return d;
	endfunction

	// One clock edge of the expected Y axis
	task automatic step_y_model(input logic pkt, input logic [23:0] bytes);
		int dy;
		if (stick_a_i != '0 || cpu_halt_i) begin
			y_exp   = 0;
			emu_exp = 1'b0;
		end else if (pkt) begin
			dy = limited_step(bytes[5], bytes[23:16]);
			if (invert_y_i) begin
				dy = -dy;
			end
			y_exp = y_exp + dy;
			if (y_exp > int'(io_bridge_pkg::AXIS_MAX)) begin
				y_exp = int'(io_bridge_pkg::AXIS_MAX);
			end else if (y_exp < int'(io_bridge_pkg::AXIS_MIN)) begin
				y_exp = int'(io_bridge_pkg::AXIS_MIN);
			end
			emu_exp = 1'b1;
		end
	endtask

	// Port 2 Y is stick B, or the port 1 Y when the ports are swapped
	function automatic logic [7:0] port2_y_expected();
		logic [7:0] y;
		if (!swap_i) begin
			y = stick_b_i[15:8];
		end else if (emu_exp) begin
			y = y_exp[7:0];
		end else begin
			y = stick_a_i[15:8];
		end
		return y;
	endfunction

	task automatic run_record(input int idx);
		tb_cmd_e     cmd;
		logic [31:0] op_a;
		logic [31:0] op_b;
		logic [31:0] expected;
		string       name;
		int          reps;
		int          waited;
		logic        ack_was;
		int          base;
		base = idx * REC_WORDS;
		if (stim_mem[base] > 32'd9) begin
			fail_run($sformatf("record %0d holds an unknown command code", idx));
		end
		cmd      = tb_cmd_e'(stim_mem[base][3:0]);
		op_a     = stim_mem[base+1];
		op_b     = stim_mem[base+2];
		expected = stim_mem[base+3];
		name     = $sformatf("rec%0d_%s", idx, cmd.name());
		case (cmd)
			MOUSE: begin
				invert_y_i = op_b[0];
				swap_i     = op_b[1];
				reps       = int'(op_b[15:8]);
				for (int r = 0; r < reps; r++) begin
					// Each new packet flips the toggle bit
					mouse_tog = ~mouse_tog;
					mouse_i   = {mouse_tog, op_a[23:0]};
					step_y_model(1'b1, op_a[23:0]);
					next_edge();
				end
				check_value(name, expected, joy_probe());
				check_value({name, "_joy2y"}, {24'h0, port2_y_expected()}, {24'h0, joy2y_o});
			end
			STICK, HALT: begin
				invert_y_i = op_b[0];
				swap_i     = op_b[1];
				if (cmd == STICK) begin
					stick_a_i = op_a[15:0];
				end else begin
					cpu_halt_i = op_a[0];
				end
				step_y_model(1'b0, '0);
				next_edge();
				check_value(name, expected, joy_probe());
				check_value({name, "_joy2y"}, {24'h0, port2_y_expected()}, {24'h0, joy2y_o});
			end
			CTLWR: begin
				ctl_sel_i     = op_b[5:0];
				ctl_data_i    = op_a;
				ctl_data_wr_i = 1'b1;
				next_edge();
				ctl_data_wr_i = 1'b0;
				next_edge();
				check_value(name, expected, sd_lba_o);
				// Address steps one edge after a buffer write
				next_edge();
				if (op_b[8]) begin
					pulse_io_wr();
				end
			end
			CTLRD: begin
				ctl_sel_i = op_b[5:0];
				next_edge();
				check_value(name, expected, ctl_word_o);
				ctl_data_rd_i = 1'b1;
				next_edge();
				ctl_data_rd_i = 1'b0;
				next_edge();
				if (op_b[8]) begin
					pulse_io_wr();
				end
			end
			BLOCK: begin
				ctl_sel_i = op_b[5:0];
				next_edge();
				check_value(name, expected, disk_probe());
			end
			ACK: begin
				ack_was  = |sd_ack_i;
				sd_ack_i = op_a[2:0];
				next_edge();
				if (ack_was && sd_ack_i == '0) begin
					waited = 0;
					while (!status_o[0] && waited < DONE_TIMEOUT) begin
						next_edge();
						waited++;
					end
					if (!status_o[0]) begin
						fail_run($sformatf("%s timed out waiting for io_done", name));
					end
				end
				check_value(name, expected, disk_probe());
			end
			MOUNT: begin
				img_size_i     = op_a;
				img_mounted_i  = op_b[2:0];
				img_type_i     = op_b[5:4];
				img_readonly_i = op_b[8];
				next_edge();
				check_value(name, expected, disk_probe());
			end
			HOSTWR: begin
				host_addr_i = op_a[8:0];
				host_data_i = op_b[7:0];
				host_wr_i   = 1'b1;
				next_edge();
				host_wr_i = 1'b0;
				next_edge();
				check_value(name, expected, {24'h0, host_data_o});
			end
			default: begin
				host_addr_i = op_a[8:0];
				next_edge();
				check_value(name, expected, {24'h0, host_data_o});
			end
		endcase
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		int rec;
		for (int w = 0; w < MAX_RECS*REC_WORDS; w++) begin
			stim_mem[w] = '1;
		end
		$readmemh("test/stim_input.txt", stim_mem);

		areset         = 1'b1;
		mouse_tog      = 1'b0;
		y_exp          = 0;
		emu_exp        = 1'b0;
		mouse_i        = '0;
		invert_y_i     = 1'b0;
		cpu_halt_i     = 1'b0;
		stick_a_i      = '0;
		stick_b_i      = 16'h3355;
		joy_a_i        = '0;
		joy_b_i        = '0;
		swap_i         = 1'b0;
		ctl_sel_i      = '0;
		ctl_data_i     = '0;
		ctl_data_wr_i  = 1'b0;
		ctl_data_rd_i  = 1'b0;
		ctl_io_wr_i    = 1'b0;
		sd_ack_i       = '0;
		img_mounted_i  = '0;
		img_readonly_i = 1'b0;
		img_size_i     = '0;
		img_type_i     = '0;
		host_addr_i    = '0;
		host_data_i    = '0;
		host_wr_i      = 1'b0;

		repeat (2) @(posedge clk_sys);
		#5;
		areset = 1'b0;

		if (stim_mem[0] === '1) begin
			fail_run("the stimulus file held no records");
		end
		rec = 0;
		while (rec < MAX_RECS && stim_mem[rec*REC_WORDS] !== '1) begin
			run_record(rec);
			rec++;
		end
		$display("%0d records checked", rec);
		$display("** PASS **");
		$finish;
	end

endmodule

/* test/emu_io_chk.sv */
// Concurrent checks on the I/O bridge top level, bound into the DUT by the testbench
`timescale 1ns/1ps

module emu_io_chk (
	input logic                                 clk_sys,
	input logic                                 areset,
	input logic [io_bridge_pkg::DRIVE_SLOTS-1:0] ack_i,
	input logic [io_bridge_pkg::DRIVE_SLOTS-1:0] rd_req_i,
	input logic [io_bridge_pkg::DRIVE_SLOTS-1:0] wr_req_i,
	input logic [7:0]                           status_i,
	input io_bridge_pkg::axis_t                 axis_x_i,
	input io_bridge_pkg::axis_t                 axis_y_i
);

	// Any ack drops every pending request
	ack_clears_req: assert property (@(posedge clk_sys) disable iff (areset)
		(|ack_i) |=> (rd_req_i == '0 && wr_req_i == '0))
		else $error("request bits still set the cycle after an ack");

	// Done follows an ack that was high and then fell
	done_needs_ack: assert property (@(posedge clk_sys) disable iff (areset)
		$rose(status_i[0]) |-> ($past(|ack_i, 2) && !$past(|ack_i)))
		else $error("io_done rose without a falling ack");

	axis_in_range: assert property (@(posedge clk_sys) disable iff (areset)
		axis_x_i >= io_bridge_pkg::AXIS_MIN && axis_x_i <= io_bridge_pkg::AXIS_MAX &&
		axis_y_i >= io_bridge_pkg::AXIS_MIN && axis_y_i <= io_bridge_pkg::AXIS_MAX)
		else $error("an axis left the saturation bounds");

endmodule

/* hdl/emu_io_top.sv */
// Top level of the I/O bridge, wiring the mouse-paddle path and the disk path on plain ports
`timescale 1ns/1ps

module emu_io_top (
	input  logic                                 clk_sys,
	input  logic                                 areset,
	// Mouse and joysticks
	input  logic [24:0]                          mouse_i,
	input  logic                                 invert_y_i,
	input  logic                                 cpu_halt_i,
	input  logic [15:0]                          stick_a_i,
	input  logic [15:0]                          stick_b_i,
	input  logic [13:0]                          joy_a_i,
	input  logic [13:0]                          joy_b_i,
	input  logic                                 swap_i,
	output logic [7:0]                           joy1x_o,
	output logic [7:0]                           joy1y_o,
	output logic [7:0]                           joy2x_o,
	output logic [7:0]                           joy2y_o,
	output logic [13:0]                          joy1_o,
	output logic [13:0]                          joy2_o,
	// Disk controller side
	input  logic [5:0]                           ctl_sel_i,
	input  io_bridge_pkg::lba_t                  ctl_data_i,
	input  logic                                 ctl_data_wr_i,
	input  logic                                 ctl_data_rd_i,
	input  logic                                 ctl_io_wr_i,
	output logic [7:0]                           status_o,
	output io_bridge_pkg::lba_t                  ctl_word_o,
	// Host block-device side
	output io_bridge_pkg::lba_t                  sd_lba_o,
	output logic [io_bridge_pkg::DRIVE_SLOTS-1:0] sd_rd_o,
	output logic [io_bridge_pkg::DRIVE_SLOTS-1:0] sd_wr_o,
	input  logic [io_bridge_pkg::DRIVE_SLOTS-1:0] sd_ack_i,
	input  logic [io_bridge_pkg::DRIVE_SLOTS-1:0] img_mounted_i,
	input  logic                                 img_readonly_i,
	input  io_bridge_pkg::lba_t                  img_size_i,
	input  logic [1:0]                           img_type_i,
	input  io_bridge_pkg::buf_addr_t             host_addr_i,
	input  logic [7:0]                           host_data_i,
	input  logic                                 host_wr_i,
	output logic [7:0]                           host_data_o
);

	// ========================================================================
	// Mouse to paddle path
	// ========================================================================

	mouse_step_if step_bus [io_bridge_pkg::AXIS_COUNT] ();

	io_bridge_pkg::axis_t axis_val [io_bridge_pkg::AXIS_COUNT];

	logic stick_active;

	// Any stick A movement hands the axes back to the real stick
	assign stick_active = |stick_a_i;

	mouse_packet_decoder u_decoder (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.mouse_i        (mouse_i),
		.invert_y_i     (invert_y_i),
		.stick_active_i (stick_active),
		.halt_i         (cpu_halt_i),
		.step_o         (step_bus)
	);

	for (genvar i = 0; i < io_bridge_pkg::AXIS_COUNT; i++) begin : g_axis
		axis_integrator u_axis (
			.clk_sys (clk_sys),
			.areset  (areset),
			.step    (step_bus[i]),
			.axis_o  (axis_val[i])
		);
	end

	// Axes stay within a signed byte, so the low byte is the paddle value
	joystick_select u_joy_sel (
		.mouse_x_i       (axis_val[0][7:0]),
		.mouse_y_i       (axis_val[1][7:0]),
		.active_i        (step_bus[0].active),
		.mouse_buttons_i (mouse_i[1:0]),
		.stick_a_i       (stick_a_i),
		.stick_b_i       (stick_b_i),
		.joy_a_i         (joy_a_i),
		.joy_b_i         (joy_b_i),
		.swap_i          (swap_i),
		.joy1x_o         (joy1x_o),
		.joy1y_o         (joy1y_o),
		.joy2x_o         (joy2x_o),
		.joy2y_o         (joy2y_o),
		.joy1_o          (joy1_o),
		.joy2_o          (joy2_o)
	);

	// ========================================================================
	// Disk path
	// ========================================================================

	buffer_port_if buf_bus ();

	sector_buffer u_buffer (
		.clk_sys     (clk_sys),
		.host_addr_i (host_addr_i),
		.host_data_i (host_data_i),
		.host_wr_i   (host_wr_i),
		.host_data_o (host_data_o),
		.ctl         (buf_bus)
	);

	disk_bridge u_disk (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.ctl_sel_i      (ctl_sel_i),
		.ctl_data_i     (ctl_data_i),
		.ctl_data_wr_i  (ctl_data_wr_i),
		.ctl_data_rd_i  (ctl_data_rd_i),
		.ctl_io_wr_i    (ctl_io_wr_i),
		.status_o       (status_o),
		.ctl_word_o     (ctl_word_o),
		.sd_lba_o       (sd_lba_o),
		.sd_rd_o        (sd_rd_o),
		.sd_wr_o        (sd_wr_o),
		.sd_ack_i       (sd_ack_i),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i),
		.buf_port       (buf_bus)
	);

endmodule

/* hdl/disk_bridge.sv */
// Disk bridge between the emulated controller strobes and the host block-device service
`timescale 1ns/1ps

module disk_bridge (
	input  logic                                 clk_sys,
	input  logic                                 areset,
	input  logic [5:0]                           ctl_sel_i,
	input  io_bridge_pkg::lba_t                  ctl_data_i,
	input  logic                                 ctl_data_wr_i,
	input  logic                                 ctl_data_rd_i,
	input  logic                                 ctl_io_wr_i,
	output logic [7:0]                           status_o,
	output io_bridge_pkg::lba_t                  ctl_word_o,
	output io_bridge_pkg::lba_t                  sd_lba_o,
	output logic [io_bridge_pkg::DRIVE_SLOTS-1:0] sd_rd_o,
	output logic [io_bridge_pkg::DRIVE_SLOTS-1:0] sd_wr_o,
	input  logic [io_bridge_pkg::DRIVE_SLOTS-1:0] sd_ack_i,
	input  logic [io_bridge_pkg::DRIVE_SLOTS-1:0] img_mounted_i,
	input  logic                                 img_readonly_i,
	input  io_bridge_pkg::lba_t                  img_size_i,
	input  logic [1:0]                           img_type_i,
	buffer_port_if.controller                    buf_port
);

	// ========================================================================
	// Controller select fields
	// ========================================================================

	logic                       lba_mode;
	logic                       block_rd;
	logic                       block_wr;
	io_bridge_pkg::drive_slot_t slot;

	assign lba_mode = ctl_sel_i[0];
	assign block_rd = ctl_sel_i[1];
	assign block_wr = ctl_sel_i[2];
	// Drives 0, 1 and 4 map onto slots 0, 1 and 2
	assign slot     = {ctl_sel_i[5], ctl_sel_i[3]};

	// Strobe history for edge detection
	logic data_wr_q1;
	logic data_wr_q2;
	logic data_rd_q;
	logic blk_rd_q;
	logic blk_wr_q;
	logic ack_q;
	logic mount_q;

	logic data_wr_rise;
	logic any_ack;
	logic any_mount;
	logic wr_done;

	io_bridge_pkg::buf_addr_t addr;

	logic       io_done;
	logic       mounted;
	logic [2:0] fileno;
	logic [1:0] file_type;
	logic       read_only;

	io_bridge_pkg::lba_t file_size;

	assign data_wr_rise = data_wr_q1 & ~data_wr_q2;
	assign any_ack      = |sd_ack_i;
	assign any_mount    = |img_mounted_i;

	// Buffer write lands on the same edge as an LBA load would
	assign buf_port.addr  = addr;
	assign buf_port.wdata = ctl_data_i[7:0];
	assign buf_port.wr    = data_wr_rise & ~lba_mode;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			data_wr_q1 <= 1'b0;
			data_wr_q2 <= 1'b0;
			data_rd_q  <= 1'b0;
			blk_rd_q   <= 1'b0;
			blk_wr_q   <= 1'b0;
			ack_q      <= 1'b0;
			mount_q    <= 1'b0;
			wr_done    <= 1'b0;
			addr       <= '0;
			sd_rd_o    <= '0;
			sd_wr_o    <= '0;
			io_done    <= 1'b0;
			mounted    <= 1'b0;
		end else begin
			data_wr_q1 <= ctl_data_wr_i;
			data_wr_q2 <= data_wr_q1;
			data_rd_q  <= ctl_data_rd_i;
			blk_rd_q   <= block_rd;
			blk_wr_q   <= block_wr;
			ack_q      <= any_ack;
			mount_q    <= any_mount;
			wr_done    <= buf_port.wr;

			if (data_wr_rise && lba_mode) begin
				sd_lba_o <= ctl_data_i;
			end

			// Address moves after a write or a finished read, io_wr rewinds it
			if (wr_done) begin
				addr <= addr + 1'b1;
			end
			if (data_rd_q && !ctl_data_rd_i) begin
				addr <= addr + 1'b1;
			end
			if (ctl_io_wr_i) begin
				addr <= '0;
			end

			if (block_rd && !blk_rd_q && slot < io_bridge_pkg::DRIVE_SLOTS) begin
				sd_rd_o[slot] <= 1'b1;
				io_done       <= 1'b0;
			end
			if (block_wr && !blk_wr_q && slot < io_bridge_pkg::DRIVE_SLOTS) begin
				sd_wr_o[slot] <= 1'b1;
				io_done       <= 1'b0;
			end
			if (any_ack) begin
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end
			if (ack_q && !any_ack) begin
				io_done <= 1'b1;
			end

			// Image change notice from the host
			if (any_mount && !mount_q) begin
				for (int s = 0; s < io_bridge_pkg::DRIVE_SLOTS; s++) begin
					if (img_mounted_i[s]) begin
						fileno <= io_bridge_pkg::SLOT_FILENO[s];
					end
				end
				file_type <= img_type_i;
				read_only <= img_readonly_i | img_mounted_i[io_bridge_pkg::DRIVE_SLOTS-1];
				file_size <= img_size_i;
				mounted   <= ~mounted;
			end
		end
	end

	assign status_o   = {read_only, file_type, fileno, mounted, io_done};
	assign ctl_word_o = lba_mode ? file_size : {24'd0, buf_port.rdata};

endmodule

/* hdl/sector_buffer.sv */
// Sector buffer: 512x8 dual-port RAM, host port on plain ports and controller port on an interface
`timescale 1ns/1ps

interface buffer_port_if;
	io_bridge_pkg::buf_addr_t addr;
	logic [7:0]               wdata;
	logic                     wr;
	// Word at the previous cycle's addr
	logic [7:0]               rdata;

	modport controller (output addr, output wdata, output wr, input rdata);
	modport memory (input addr, input wdata, input wr, output rdata);
endinterface

module sector_buffer (
	input  logic                      clk_sys,
	input  io_bridge_pkg::buf_addr_t  host_addr_i,
	input  logic [7:0]                host_data_i,
	input  logic                      host_wr_i,
	output logic [7:0]                host_data_o,
	buffer_port_if.memory             ctl
);

	logic [7:0] mem [io_bridge_pkg::SECTOR_BYTES];

	// Both ports read old data on a same-address write
	always_ff @(posedge clk_sys) begin
		if (host_wr_i) begin
			mem[host_addr_i] <= host_data_i;
		end
		if (ctl.wr) begin
			mem[ctl.addr] <= ctl.wdata;
		end
		host_data_o <= mem[host_addr_i];
		ctl.rdata   <= mem[ctl.addr];
	end

endmodule

/* hdl/joystick_select.sv */
// Joystick selector: mouse or analog stick onto port 1, button merge and port swap
`timescale 1ns/1ps

module joystick_select (
	input  logic [7:0]  mouse_x_i,
	input  logic [7:0]  mouse_y_i,
	input  logic        active_i,
	input  logic [1:0]  mouse_buttons_i,
	input  logic [15:0] stick_a_i,
	input  logic [15:0] stick_b_i,
	input  logic [13:0] joy_a_i,
	input  logic [13:0] joy_b_i,
	input  logic        swap_i,
	output logic [7:0]  joy1x_o,
	output logic [7:0]  joy1y_o,
	output logic [7:0]  joy2x_o,
	output logic [7:0]  joy2y_o,
	output logic [13:0] joy1_o,
	output logic [13:0] joy2_o
);

	logic [7:0]  p1_x;
	logic [7:0]  p1_y;
	logic [13:0] p1_btn;

	// Stick A carries X in the low byte and Y in the high byte
	assign p1_x = active_i ? mouse_x_i : stick_a_i[7:0];
	assign p1_y = active_i ? mouse_y_i : stick_a_i[15:8];

	// Mouse buttons stand in for fire 2 and fire 3
	assign p1_btn = {joy_a_i[13:9], active_i ? mouse_buttons_i : joy_a_i[8:7], joy_a_i[6:0]};

	assign joy1x_o = swap_i ? stick_b_i[7:0]  : p1_x;
	assign joy1y_o = swap_i ? stick_b_i[15:8] : p1_y;
	assign joy2x_o = swap_i ? p1_x : stick_b_i[7:0];
	assign joy2y_o = swap_i ? p1_y : stick_b_i[15:8];

	assign joy1_o = swap_i ? joy_b_i : p1_btn;
	assign joy2_o = swap_i ? p1_btn  : joy_b_i;

endmodule

/* hdl/axis_integrator.sv */
// Saturating accumulator for one emulated paddle axis, fed by the mouse step interface
`timescale 1ns/1ps

module axis_integrator (
	input  logic                 clk_sys,
	input  logic                 areset,
	mouse_step_if.sink           step,
	output io_bridge_pkg::axis_t axis_o
);

	io_bridge_pkg::axis_t sum;

	// Cannot overflow 9 bits since the step is limited
	assign sum = axis_o + step.delta;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			axis_o <= '0;
		end else if (step.clear) begin
			axis_o <= '0;
		end else if (step.step_stb) begin
			if (sum > io_bridge_pkg::AXIS_MAX) begin
				axis_o <= io_bridge_pkg::AXIS_MAX;
			end else if (sum < io_bridge_pkg::AXIS_MIN) begin
				axis_o <= io_bridge_pkg::AXIS_MIN;
			end else begin
				axis_o <= sum;
			end
		end
	end

endmodule

/* hdl/mouse_packet_decoder.sv */
// Mouse packet decoder: finds new packets, limits both deltas and owns the emulation flag
`timescale 1ns/1ps

module mouse_packet_decoder (
	input  logic         clk_sys,
	input  logic         areset,
	input  logic [24:0]  mouse_i,
	input  logic         invert_y_i,
	input  logic         stick_active_i,
	input  logic         halt_i,
	mouse_step_if.source step_o [io_bridge_pkg::AXIS_COUNT]
);

	logic tog_q;
	logic active_q;
	logic new_pkt;
	logic take_over;

	io_bridge_pkg::axis_t raw_delta [io_bridge_pkg::AXIS_COUNT];
	io_bridge_pkg::axis_t lim_delta [io_bridge_pkg::AXIS_COUNT];

	// Bit 24 toggles once per packet
	assign new_pkt   = mouse_i[24] != tog_q;
	assign take_over = stick_active_i | halt_i;

	// Sign bits live in byte 0, X magnitude in byte 1, Y in byte 2
	assign raw_delta[0] = {mouse_i[4], mouse_i[15:8]};
	assign raw_delta[1] = {mouse_i[5], mouse_i[23:16]};

	always_ff @(posedge clk_sys) begin
		tog_q <= mouse_i[24];
		if (areset) begin
			active_q <= 1'b0;
		end else if (take_over) begin
			active_q <= 1'b0;
		end else if (new_pkt) begin
			active_q <= 1'b1;
		end
	end

	for (genvar i = 0; i < io_bridge_pkg::AXIS_COUNT; i++) begin : g_step
		always_comb begin
			if (raw_delta[i] > io_bridge_pkg::STEP_LIMIT) begin
				lim_delta[i] = io_bridge_pkg::axis_t'(io_bridge_pkg::STEP_LIMIT);
			end else if (raw_delta[i] < -io_bridge_pkg::STEP_LIMIT) begin
				lim_delta[i] = io_bridge_pkg::axis_t'(-io_bridge_pkg::STEP_LIMIT);
			end else begin
				lim_delta[i] = raw_delta[i];
			end
		end

		assign step_o[i].step_stb = new_pkt;
		// Only the Y axis follows the invert option
		assign step_o[i].delta    = (i == 1 && invert_y_i) ? -lim_delta[i] : lim_delta[i];
		assign step_o[i].clear    = take_over;
		assign step_o[i].active   = active_q;
	end

endmodule

/* hdl/mouse_step_if.sv */
// One axis step from the mouse packet decoder to an axis integrator, one instance per axis
`timescale 1ns/1ps

interface mouse_step_if;

	// Single-cycle strobe, no back-pressure
	logic                 step_stb;
	// Limited signed step for this axis
	io_bridge_pkg::axis_t delta;
	// Return to zero, wins over step_stb
	logic                 clear;
	// Mouse emulation currently owns the axis
	logic                 active;

	modport source (
		output step_stb,
		output delta,
		output clear,
		output active
	);

	modport sink (
		input step_stb,
		input delta,
		input clear,
		input active
	);

endinterface

/* hdl/io_bridge_pkg.sv */
// Shared constants and types for the mouse-paddle and disk bridge paths, referenced by scope
package io_bridge_pkg;

	// ========================================================================
	// Mouse to paddle emulation
	// ========================================================================

	// One bit wider than the paddle byte so a sum can be checked before clamping
	typedef logic signed [8:0] axis_t;

	localparam axis_t AXIS_MAX = 9'sd127;
	localparam axis_t AXIS_MIN = -9'sd128;

	// Largest magnitude of a single mouse step
	localparam int STEP_LIMIT = 10;

	// Axis 0 is X, axis 1 is Y
	localparam int AXIS_COUNT = 2;

	// ========================================================================
	// Disk bridge
	// ========================================================================

	localparam int SECTOR_BYTES = 512;
	typedef logic [$clog2(SECTOR_BYTES)-1:0] buf_addr_t;

	localparam int DRIVE_SLOTS = 3;
	typedef logic [1:0] drive_slot_t;

	// Controller file number reported for each host slot
	localparam logic [2:0] SLOT_FILENO [DRIVE_SLOTS] = '{3'd0, 3'd1, 3'd4};

	// Block address or image size
	typedef logic [31:0] lba_t;

endpackage
